/* logic/dcache_pkg.sv */
package dcache_pkg;

    // Data path widths
    localparam int xlen            = 64;   // Data, mask and index width

    // Data-cache bank geometry
    localparam int bank_depth      = 64;   // Words in the SRAM bank
    localparam int bank_index_bits = 6;    // Low index bits used by the bank
    localparam int bank_latency    = 3;    // Cycles from the start pulse to the done pulse

    // Store queue
    localparam int sq_depth        = 4;

    // Operation carried on the transaction bus
    typedef enum logic {
        tbus_read  = 1'b0,
        tbus_write = 1'b1
    } tbus_op_t;

    // Grant state of the arbiter
    typedef enum logic [1:0] {
        arb_idle = 2'b00,    // No grant, waiting for a request
        arb_sq   = 2'b01,    // Store queue head owns the bank
        arb_load = 2'b10     // Load port owns the bank
    } arb_state_t;

    // One committed store, as held in the store queue
    typedef struct packed {
        logic [xlen-1:0] index;
        logic [xlen-1:0] write_data;
        logic [xlen-1:0] write_mask;    // Bit set means the bit is written
    } sq_entry_t;

    // Request presented to the bank
    // Loads leave write_data and write_mask at zero
    typedef struct packed {
        tbus_op_t        op;
        logic [xlen-1:0] index;
        logic [xlen-1:0] write_data;
        logic [xlen-1:0] write_mask;
    } tbus_req_t;

endpackage

/* logic/store_queue.sv */
`timescale 1ns/1ps

module store_queue
    import dcache_pkg::*;
(
    input  logic      clock,
    input  logic      reset_n,
    input  logic      push,          // One-cycle pulse per committed store
    input  sq_entry_t push_entry,
    output logic      full,
    output logic      empty,
    output logic      head_valid,
    output sq_entry_t head,          // Oldest store, presented to the arbiter
    input  logic      pop            // Completion of the head store
);

    typedef logic [$clog2(sq_depth)-1:0]   sq_ptr_t;
    typedef logic [$clog2(sq_depth+1)-1:0] sq_count_t;

    sq_entry_t entries [sq_depth];
    sq_ptr_t   wr_ptr;
    sq_ptr_t   rd_ptr;
    sq_count_t count;
    logic      do_push;
    logic      do_pop;

    // Pointer step with wrap at the last entry
    function automatic sq_ptr_t next_ptr(input sq_ptr_t ptr);
        if (ptr == sq_ptr_t'(sq_depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign do_push = push & ~full;    // A push into a full queue is lost
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Idle, or push and pop together
            endcase
        end
    end

    // Entry storage
    always_ff @(posedge clock) begin
        if (do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    assign empty      = (count == '0);
    assign full       = (count == sq_count_t'(sq_depth));
    assign head_valid = ~empty;
    assign head       = entries[rd_ptr];

endmodule

/* logic/dcache_bank.sv */
`timescale 1ns/1ps

module dcache_bank
    import dcache_pkg::*;
(
    input  logic            clock,
    input  logic            reset_n,
    input  logic            start,       // Start pulse taken only while ready
    input  tbus_req_t       req,
    input  logic            flush,       // Cancels a pending read
    output logic            ready,
    output logic            done,        // Pulse bank_latency cycles after start
    output logic [xlen-1:0] read_data
);

    typedef logic [$clog2(bank_latency+1)-1:0] lat_count_t;

    logic [xlen-1:0]            mem [bank_depth];
    tbus_req_t                  req_q;          // Request captured at start
    logic                       busy;           // Active flag from start until done
    logic                       done_q;
    lat_count_t                 count;          // Cycles since the start cycle
    logic [xlen-1:0]            rdata_q;
    logic [bank_index_bits-1:0] word;
    logic                       accept;
    logic                       cancel;
    logic                       finish;

    assign word   = req_q.index[bank_index_bits-1:0];
    assign accept = start & ~busy;
    assign cancel = flush & busy & (req_q.op == tbus_read);    // Writes run to the end

    // Array access in the last cycle before done
    assign finish = busy & ~cancel & (count == lat_count_t'(bank_latency - 1));

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy   <= 1'b0;
            done_q <= 1'b0;
            count  <= '0;
        end else if (accept) begin
            busy   <= 1'b1;
            done_q <= 1'b0;
            count  <= lat_count_t'(1);
        end else if (cancel) begin
            // Dropped read gets no done pulse
            busy   <= 1'b0;
            done_q <= 1'b0;
        end else if (done_q) begin
            busy   <= 1'b0;       // Ready again in the cycle after done
            done_q <= 1'b0;
        end else if (busy) begin
            count  <= count + 1'b1;
            done_q <= finish;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= req;
        end
        if (finish) begin
            if (req_q.op == tbus_write) begin
                // Per-bit merge under the write mask
                mem[word] <= (mem[word] & ~req_q.write_mask) |
                             (req_q.write_data & req_q.write_mask);
            end else begin
                rdata_q <= mem[word];
            end
        end
    end

    assign ready     = ~busy;
    assign done      = done_q;
    assign read_data = rdata_q;     // Holds until the next read

endmodule

/* logic/dcache_arb.sv */
`timescale 1ns/1ps

module dcache_arb
    import dcache_pkg::*;
(
    input  logic            clock,
    input  logic            reset_n,

    // Store queue side
    input  logic            sq_req_valid,      // Held until sq_done
    input  sq_entry_t       sq_req,
    output logic            sq_done,

    // Load port side
    input  logic            load_valid,        // Held until load_done or a flush
    input  logic [xlen-1:0] load_index,
    input  logic            load_flush,
    output logic            load_ready,
    output logic            load_done,
    output logic [xlen-1:0] load_read_data,

    // Transaction bus to the bank
    output logic            tbus_valid,        // One-cycle start pulse
    output tbus_req_t       tbus_req,
    output logic            tbus_flush,
    input  logic            tbus_ready,
    input  logic            tbus_done,
    input  logic [xlen-1:0] tbus_read_data
);

    arb_state_t      state;
    arb_state_t      next_state;
    logic            granted;       // Level while either side holds the bank
    logic            granted_q;     // Granted level delayed by one cycle
    logic            flush_now;
    logic [xlen-1:0] load_data_q;

    // Only a granted load can be cancelled
    assign flush_now = (state == arb_load) & load_flush;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= arb_idle;
        end else begin
            state <= next_state;
        end
    end

    // Strict store priority and loads only with an empty store queue
    always_comb begin
        next_state = state;
        case (state)
            arb_idle: begin
                if (tbus_ready) begin
                    if (sq_req_valid) begin
                        next_state = arb_sq;
                    end else if (load_valid && !load_flush) begin
                        next_state = arb_load;
                    end
                end
            end
            arb_sq: begin
                if (tbus_done) begin
                    next_state = arb_idle;
                end
            end
            arb_load: begin
                if (load_flush || tbus_done) begin
                    next_state = arb_idle;
                end
            end
            default: next_state = arb_idle;
        endcase
    end

    // Request mux with the op taken from the grant
    always_comb begin
        tbus_req = '0;
        case (state)
            arb_sq: begin
                tbus_req.op         = tbus_write;
                tbus_req.index      = sq_req.index;
                tbus_req.write_data = sq_req.write_data;
                tbus_req.write_mask = sq_req.write_mask;
            end
            arb_load: begin
                tbus_req.op    = tbus_read;
                tbus_req.index = load_index;
            end
            default: tbus_req = '0;
        endcase
    end

    // Rising edge of the grant gives the start pulse
    assign granted = (state != arb_idle);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            granted_q <= 1'b0;
        end else begin
            granted_q <= granted;
        end
    end

    assign tbus_valid = granted & ~granted_q & ~flush_now;
    assign tbus_flush = flush_now;

    // Completion goes straight back to the owner of the grant
    assign sq_done    = (state == arb_sq) & tbus_done;
    assign load_done  = (state == arb_load) & tbus_done & ~load_flush;
    assign load_ready = (state == arb_load) & tbus_ready;

    always_ff @(posedge clock) begin
        if (load_done) begin
            load_data_q <= tbus_read_data;
        end
    end

    // New data shows in the done cycle and the held copy after it
    assign load_read_data = load_done ? tbus_read_data : load_data_q;

endmodule

/* logic/dcache_subsys.sv */
`timescale 1ns/1ps

module dcache_subsys
    import dcache_pkg::*;
(
    input  logic            clock,
    input  logic            reset_n,

    // Committed stores
    input  logic            store_push,
    input  sq_entry_t       store_entry,
    output logic            sq_full,
    output logic            sq_empty,

    // Load port
    input  logic            load_valid,
    input  logic [xlen-1:0] load_index,
    input  logic            load_flush,
    output logic            load_ready,
    output logic            load_done,
    output logic [xlen-1:0] load_read_data
);

    logic            sq_req_valid;
    sq_entry_t       sq_req;
    logic            sq_done;
    logic            tbus_valid;
    tbus_req_t       tbus_req;
    logic            tbus_flush;
    logic            tbus_ready;
    logic            tbus_done;
    logic [xlen-1:0] tbus_read_data;

    store_queue i_store_queue (
        .clock      (clock),
        .reset_n    (reset_n),
        .push       (store_push),
        .push_entry (store_entry),
        .full       (sq_full),
        .empty      (sq_empty),
        .head_valid (sq_req_valid),
        .head       (sq_req),
        .pop        (sq_done)       // Head leaves when its write completes
    );

    dcache_arb i_dcache_arb (
        .clock          (clock),
        .reset_n        (reset_n),
        .sq_req_valid   (sq_req_valid),
        .sq_req         (sq_req),
        .sq_done        (sq_done),
        .load_valid     (load_valid),
        .load_index     (load_index),
        .load_flush     (load_flush),
        .load_ready     (load_ready),
        .load_done      (load_done),
        .load_read_data (load_read_data),
        .tbus_valid     (tbus_valid),
        .tbus_req       (tbus_req),
        .tbus_flush     (tbus_flush),
        .tbus_ready     (tbus_ready),
        .tbus_done      (tbus_done),
        .tbus_read_data (tbus_read_data)
    );

    dcache_bank i_dcache_bank (
        .clock     (clock),
        .reset_n   (reset_n),
        .start     (tbus_valid),
        .req       (tbus_req),
        .flush     (tbus_flush),
        .ready     (tbus_ready),
        .done      (tbus_done),
        .read_data (tbus_read_data)
    );

endmodule

/* dv/dcache_subsys_tb.sv */
`timescale 1ns/1ps

module dcache_subsys_tb
    import dcache_pkg::*;
();

    localparam int    clock_period = 100;
    localparam int    wait_limit   = 200;                   // Cycles allowed for any one wait
    localparam int    flush_watch  = 4 * bank_latency + 8;  // Cycles watched after a flush
    localparam string pattern_file = "dv/dcache_patterns.txt";

    logic            clock;
    logic            reset_n;
    logic            store_push;
    sq_entry_t       store_entry;
    logic            sq_full;
    logic            sq_empty;
    logic            load_valid;
    logic [xlen-1:0] load_index;
    logic            load_flush;
    logic            load_ready;
    logic            load_done;
    logic [xlen-1:0] load_read_data;

    logic [xlen-1:0] model_mem [bank_depth];    // Expected bank contents
    logic [31:0]     lfsr_state;
    int              error_count;
    int              timeout_count;

    dcache_subsys i_dut (
        .clock          (clock),
        .reset_n        (reset_n),
        .store_push     (store_push),
        .store_entry    (store_entry),
        .sq_full        (sq_full),
        .sq_empty       (sq_empty),
        .load_valid     (load_valid),
        .load_index     (load_index),
        .load_flush     (load_flush),
        .load_ready     (load_ready),
        .load_done      (load_done),
        .load_read_data (load_read_data)
    );

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    // Right-shift Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic take_bits(input int n, output logic [xlen-1:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[xlen-2:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            error_count++;
            $display("Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // Each bit set in the mask takes the new data bit
    function automatic void model_write(input sq_entry_t entry);
        logic [bank_index_bits-1:0] word;
        word = entry.index[bank_index_bits-1:0];
        for (int b = 0; b < xlen; b++) begin
            if (entry.write_mask[b]) begin
                model_mem[word][b] = entry.write_data[b];
            end
        end
    endfunction

    // Called on a falling edge and returns one cycle after the push
    task automatic push_store(input string name, input sq_entry_t entry);
        int cycles;
        cycles = 0;
        while (sq_full && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (sq_full) begin
            timeout_count++;
            $display("%s: store queue stayed full, store was not pushed", name);
        end else begin
            store_push  = 1'b1;
            store_entry = entry;
            model_write(entry);
            @(negedge clock);
            store_push  = 1'b0;
        end
    endtask

    task automatic do_load(input string name, input logic [xlen-1:0] index);
        int              cycles;
        logic            ready_seen;
        logic [xlen-1:0] expected;
        cycles     = 0;
        ready_seen = 1'b0;
        expected   = model_mem[index[bank_index_bits-1:0]];
        load_valid = 1'b1;
        load_index = index;
        do begin
            @(negedge clock);
            cycles++;
            ready_seen = ready_seen | load_ready;
        end while (!load_done && cycles < wait_limit);
        if (load_done) begin
            check_value(name, expected, load_read_data);
            check_value($sformatf("%s load_ready seen", name), xlen'(1), xlen'(ready_seen));
            load_valid = 1'b0;
            @(negedge clock);
            check_value($sformatf("%s data held", name), expected, load_read_data);
        end else begin
            timeout_count++;
            $display("%s: load got no done pulse within %0d cycles", name, wait_limit);
            load_valid = 1'b0;
        end
    endtask

    // Load cancelled after delay cycles with no done afterwards
    task automatic flush_load(input string name, input logic [xlen-1:0] index,
                              input int delay);
        load_valid = 1'b1;
        load_index = index;
        repeat (delay) begin
            @(negedge clock);
            check_value($sformatf("%s done before flush", name), '0, xlen'(load_done));
        end
        load_flush = 1'b1;
        @(negedge clock);
        load_valid = 1'b0;
        load_flush = 1'b0;
        repeat (flush_watch) begin
            check_value($sformatf("%s done after flush", name), '0, xlen'(load_done));
            @(negedge clock);
        end
    endtask

    task automatic wait_empty(input string name);
        int cycles;
        cycles = 0;
        while (!sq_empty && cycles < wait_limit) begin
            @(negedge clock);
            cycles++;
        end
        if (!sq_empty) begin
            timeout_count++;
            $display("%s: store queue did not drain within %0d cycles", name, wait_limit);
        end
    endtask

    task automatic random_mix(input string name, input int count);
        logic [xlen-1:0] kind;
        logic [xlen-1:0] index;
        logic [xlen-1:0] data;
        logic [xlen-1:0] mask;
        sq_entry_t       entry;
        for (int i = 0; i < count; i++) begin
            take_bits(1, kind);
            take_bits(bank_index_bits, index);
            if (kind[0]) begin
                take_bits(xlen, data);
                take_bits(xlen, mask);
                entry.index      = index;
                entry.write_data = data;
                entry.write_mask = mask;
                push_store($sformatf("%s store %0d", name, i), entry);
            end else begin
                do_load($sformatf("%s load %0d", name, i), index);
            end
        end
    endtask

    initial begin
        int              fd;
        int              line_no;
        int              fields;
        string           line;
        string           name;
        logic [63:0]     cmd;
        logic [xlen-1:0] arg_a;
        logic [xlen-1:0] arg_b;
        logic [xlen-1:0] arg_c;
        sq_entry_t       entry;

        error_count   = 0;
        timeout_count = 0;
        lfsr_state    = 32'ha638_6deb;
        reset_n       = 1'b0;
        store_push    = 1'b0;
        store_entry   = '0;
        load_valid    = 1'b0;
        load_index    = '0;
        load_flush    = 1'b0;
        for (int i = 0; i < bank_depth; i++) begin
            model_mem[i] = '0;
        end

        repeat (2) @(negedge clock);
        reset_n = 1'b1;
        @(negedge clock);
        check_value("reset sq_empty", xlen'(1), xlen'(sq_empty));
        check_value("reset sq_full", '0, xlen'(sq_full));
        check_value("reset load_ready", '0, xlen'(load_ready));
        check_value("reset load_done", '0, xlen'(load_done));

        fd = $fopen(pattern_file, "r");
        if (fd == 0) begin
            error_count++;
            $display("Could not open the pattern file %s", pattern_file);
        end else begin
            line_no = 0;
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                cmd    = '0;
                fields = $sscanf(line, "%s %h %h %h", cmd, arg_a, arg_b, arg_c);
                if (fields < 1 || line.getc(0) == "#") begin
                    continue;    // Blank or comment line
                end
                name = $sformatf("line %0d", line_no);
                case (cmd)
                    64'("store"): begin
                        entry.index      = arg_a;
                        entry.write_data = arg_b;
                        entry.write_mask = arg_c;
                        push_store($sformatf("%s store %0h", name, arg_a), entry);
                    end
                    64'("load"):   do_load($sformatf("%s load %0h", name, arg_a), arg_a);
                    64'("flush"):  flush_load($sformatf("%s flush %0h", name, arg_a),
                                              arg_a, int'(arg_b));
                    64'("full"):   check_value($sformatf("%s sq_full", name), arg_a,
                                               xlen'(sq_full));
                    64'("drain"):  wait_empty($sformatf("%s drain", name));
                    64'("random"): random_mix($sformatf("%s random", name), int'(arg_a));
                    default: begin
                        error_count++;
                        $display("Unknown command in the pattern file on line %0d", line_no);
                    end
                endcase
            end
            $fclose(fd);
        end

        $display("Run finished with %0d errors and %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* dv/dcache_patterns.txt */
# Columns: command, then hex fields (index, data, mask, cycles and counts are all hex)
# store <index> <data> <mask> | load <index> | flush <index> <cycles> | full <0|1> | drain | random <count>
load 3f
store 05 0123456789abcdef ffffffffffffffff
load 05
load 2a
store 05 00000000ffffffff 0000ffff0000ffff
load 05
store 05 aaaaaaaaaaaaaaaa 0f0f0f0f0f0f0f0f
store 06 5555555555555555 ffffffff00000000
drain
load 05
load 06
store 10 1111111111111111 ffffffffffffffff
store 11 2222222222222222 ffffffffffffffff
store 10 3333333333333333 00000000ffffffff
store 10 4444444444444444 ffff000000000000
full 1
load 10
full 0
load 11
drain
flush 05 1
load 05
flush 06 2
load 06
flush 10 3
load 10
random 60
drain
load 10
load 11

/* files.f */
logic/dcache_pkg.sv
logic/store_queue.sv
logic/dcache_bank.sv
logic/dcache_arb.sv
logic/dcache_subsys.sv
dv/dcache_subsys_tb.sv

/* Makefile */
# Verilator simulation of the data-cache path

VERILATOR ?= verilator
TOP       ?= dcache_subsys_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
